// File: project.f
+incdir+bench
hdl/sort_pkg.sv
hdl/sort_stage.sv
hdl/bitonic_sorter.sv
hdl/run_min_scan.sv
hdl/lane_fifo.sv
hdl/round_robin_drain.sv
hdl/sort_reduce_top.sv
bench/tb_sort_reduce.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_sort_reduce -f project.f

out=$(./obj_dir/Vtb_sort_reduce)
echo "$out"
if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
else
    exit 1
fi

// File: bench/tb_tasks.svh
// taps 16, 14, 13, 11
function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

// sorted valid items sit above the invalid ones, data is the run minimum so far
function automatic lane_vec_t model_batch(lane_vec_t batch);
    lane_item_t s [lane_count];
    lane_item_t tmp;
    lane_vec_t  expv;
    int         n;
    int         j;
    n = 0;
    for (int i = 0; i < lane_count; i++) begin
        if (batch[i].valid) begin
            s[n] = batch[i];
            n++;
        end
    end
    for (int i = 1; i < n; i++) begin
        j = i;
        while (j > 0 && s[j - 1].key > s[j].key) begin
            tmp = s[j - 1];
            s[j - 1] = s[j];
            s[j] = tmp;
            j--;
        end
    end
    for (int i = 1; i < n; i++) begin
        if (s[i].key == s[i - 1].key && s[i - 1].data < s[i].data) begin
            s[i].data = s[i - 1].data;
        end
    end
    expv = '0;
    for (int i = 0; i < n; i++) begin
        expv[lane_count - n + i] = s[i];
    end
    return expv;
endfunction

task automatic check_item(lane_item_t got, lane_item_t want, string what);
    if (got !== want) begin
        value_errors++;
        $display("Error at %0t: %s item got %h expected %h", $time, what, got, want);
    end
endtask

task automatic check_lane(logic [lane_idx_width-1:0] got, logic [lane_idx_width-1:0] want,
                          string what);
    if (got !== want) begin
        value_errors++;
        $display("Error at %0t: %s lane got %0d expected %0d", $time, what, got, want);
    end
endtask

task automatic drive_batch(lane_vec_t b);
    @(negedge clk);
    batch_in = b;
endtask

task automatic clear_results();
    got_items.delete();
    got_lanes.delete();
endtask

task automatic wait_results(int n, string what);
    int cycles;
    cycles = 0;
    while (got_items.size() < n && cycles < 200) begin
        @(posedge clk);
        cycles++;
    end
    if (got_items.size() < n) begin
        fail_count++;
        $display("%s: gave up after 200 cycles with %0d of %0d results",
                 what, got_items.size(), n);
    end
endtask

// longer than the worst latency, so late extras still show up
task automatic expect_count(int n, string what);
    wait_results(n, what);
    repeat (20) @(posedge clk);
    if (got_items.size() != n) begin
        value_errors++;
        $display("Error at %0t: %s expected %0d results, got %0d",
                 $time, what, n, got_items.size());
    end
endtask

task automatic check_by_key(lane_vec_t expv, string what);
    int j;
    for (int k = 0; k < got_items.size(); k++) begin
        j = -1;
        for (int i = 0; i < lane_count; i++) begin
            if (expv[i].valid && expv[i].key == got_items[k].key) begin
                j = i;
            end
        end
        if (j < 0) begin
            fail_count++;
            $display("%s: result key %h does not belong to the batch", what, got_items[k].key);
        end else begin
            check_lane(got_lanes[k], lane_idx_width'(j), what);
            check_item(got_items[k], expv[j], what);
        end
    end
endtask

// oldest expected item of the same lane must match
task automatic check_by_lane(string what);
    int j;
    for (int k = 0; k < got_items.size(); k++) begin
        j = -1;
        for (int i = 0; i < exp_lanes.size() && j < 0; i++) begin
            if (exp_lanes[i] == got_lanes[k]) begin
                j = i;
            end
        end
        if (j < 0) begin
            fail_count++;
            $display("%s: result on lane %0d that nothing was expected on", what, got_lanes[k]);
        end else begin
            check_item(got_items[k], exp_items[j], what);
            exp_items.delete(j);
            exp_lanes.delete(j);
        end
    end
    if (exp_items.size() != 0) begin
        fail_count++;
        $display("%s: %0d expected results never came out", what, exp_items.size());
    end
endtask

task automatic check_group(lane_vec_t batch, logic [key_width-1:0] key, int lo, int hi,
                           string what);
    logic [data_width-1:0]     run_min;
    logic [data_width-1:0]     prev_data;
    logic [lane_idx_width-1:0] lanes [$];
    lane_item_t                by_lane [lane_count];
    lane_item_t                want_top;
    bit                        found;
    int                        cnt;
    run_min = '1;
    cnt = 0;
    for (int i = 0; i < lane_count; i++) begin
        by_lane[i] = '0;
        if (batch[i].valid && batch[i].key == key && batch[i].data < run_min) begin
            run_min = batch[i].data;
        end
    end
    for (int k = 0; k < got_items.size(); k++) begin
        if (got_items[k].key == key) begin
            cnt++;
            lanes.push_back(got_lanes[k]);
            by_lane[got_lanes[k]] = got_items[k];
            found = 1'b0;
            for (int i = 0; i < lane_count; i++) begin
                if (batch[i].valid && batch[i].key == key
                        && batch[i].data == got_items[k].data) begin
                    found = 1'b1;
                end
            end
            if (!found) begin
                value_errors++;
                $display("Error at %0t: %s data %h is no input of key %h",
                         $time, what, got_items[k].data, key);
            end
        end
    end
    if (cnt != hi - lo + 1) begin
        value_errors++;
        $display("Error at %0t: %s key %h count %0d expected %0d",
                 $time, what, key, cnt, hi - lo + 1);
    end
    lanes.sort();
    for (int m = 0; m < lanes.size(); m++) begin
        check_lane(lanes[m], lane_idx_width'(lo + m), what);
    end
    // the running minimum never rises toward higher lanes
    prev_data = '1;
    for (int m = lo; m <= hi; m++) begin
        if (by_lane[m].valid) begin
            if (by_lane[m].data > prev_data) begin
                value_errors++;
                $display("Error at %0t: %s lane %0d data %h rises above %h",
                         $time, what, m, by_lane[m].data, prev_data);
            end
            prev_data = by_lane[m].data;
        end
    end
    // top lane of a run holds the minimum of the whole run
    want_top.valid = 1'b1;
    want_top.key = key;
    want_top.data = run_min;
    check_item(by_lane[hi], want_top, what);
endtask

task automatic test_idle_after_reset();
    clear_results();
    repeat (20) @(posedge clk);
    if (got_items.size() != 0) begin
        value_errors++;
        $display("Error at %0t: after reset got %0d results", $time, got_items.size());
    end
endtask

task automatic test_reverse_keys();
    lane_vec_t b;
    lane_vec_t expv;
    clear_results();
    for (int i = 0; i < lane_count; i++) begin
        b[i].valid = 1'b1;
        b[i].key = key_width'(2048 - 256 * i);
        b[i].data = data_width'('h1000_0000 + 17 * i);
    end
    expv = model_batch(b);
    drive_batch(b);
    drive_batch('0);
    expect_count(lane_count, "reverse keys");
    check_by_key(expv, "reverse keys");
endtask

task automatic test_equal_runs();
    lane_vec_t            b;
    lane_vec_t            expv;
    logic [key_width-1:0] keys [lane_count];
    int                   lo;
    int                   hi;
    clear_results();
    keys = '{16'h0030, 16'h0010, 16'h0030, 16'h0020, 16'h0010, 16'h0030, 16'h0020, 16'h0030};
    for (int i = 0; i < lane_count; i++) begin
        b[i].valid = 1'b1;
        b[i].key = keys[i];
        b[i].data = data_width'(1000 - 37 * i + (i % 3) * 200);
    end
    expv = model_batch(b);
    drive_batch(b);
    drive_batch('0);
    expect_count(lane_count, "equal runs");
    lo = 0;
    while (lo < lane_count) begin
        hi = lo;
        while (hi + 1 < lane_count && expv[hi + 1].key == expv[lo].key) begin
            hi++;
        end
        if (expv[lo].valid) begin
            check_group(b, expv[lo].key, lo, hi, "equal runs");
        end
        lo = hi + 1;
    end
endtask

// three valid items land on lanes 5 to 7
task automatic test_sparse();
    lane_vec_t b;
    lane_vec_t expv;
    clear_results();
    b = '0;
    b[0].valid = 1'b1;
    b[0].key = 16'h0900;
    b[0].data = 32'h0000_00a0;
    b[3].valid = 1'b1;
    b[3].key = 16'h0200;
    b[3].data = 32'h0000_00b3;
    b[6].valid = 1'b1;
    b[6].key = 16'h0500;
    b[6].data = 32'h0000_00c6;
    expv = model_batch(b);
    drive_batch(b);
    drive_batch('0);
    expect_count(3, "sparse");
    check_by_key(expv, "sparse");
endtask

task automatic test_random_burst();
    lane_vec_t   b;
    lane_vec_t   expv;
    logic [31:0] r;
    int          total;
    clear_results();
    exp_items.delete();
    exp_lanes.delete();
    total = 0;
    for (int n = 0; n < 12; n++) begin
        for (int i = 0; i < lane_count; i++) begin
            r = rand_bits(1);
            b[i].valid = r[0];
            // low key bits hold the lane, so keys in a batch differ
            r = rand_bits(key_width - lane_idx_width);
            b[i].key = {r[key_width-lane_idx_width-1:0], lane_idx_width'(i)};
            b[i].data = rand_bits(data_width);
        end
        expv = model_batch(b);
        for (int i = 0; i < lane_count; i++) begin
            if (expv[i].valid) begin
                exp_items.push_back(expv[i]);
                exp_lanes.push_back(lane_idx_width'(i));
                total++;
            end
        end
        drive_batch(b);
    end
    drive_batch('0);
    expect_count(total, "random burst");
    check_by_lane("random burst");
endtask

// File: bench/tb_sort_reduce.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sort_reduce;

    import sort_pkg::*;

    logic                      clk;
    logic                      rst;
    lane_vec_t                 batch_in;
    lane_item_t                result;
    logic [lane_idx_width-1:0] result_lane;

    // every valid result, tagged with its lane
    lane_item_t                got_items [$];
    logic [lane_idx_width-1:0] got_lanes [$];

    // expected results of a burst, in write order
    lane_item_t                exp_items [$];
    logic [lane_idx_width-1:0] exp_lanes [$];

    logic [15:0] lfsr_state;
    int          value_errors;
    int          fail_count;

    sort_reduce_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .batch_in    (batch_in),
        .result      (result),
        .result_lane (result_lane)
    );

    always #5 clk = ~clk;

    // result is registered on the rising edge, so sample mid cycle
    always @(negedge clk) begin
        if (!rst && result.valid) begin
            got_items.push_back(result);
            got_lanes.push_back(result_lane);
        end
    end

    `include "tb_tasks.svh"

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        batch_in = '0;
        lfsr_state = 16'd62;
        value_errors = 0;
        fail_count = 0;

        repeat (8) @(negedge clk);
        rst = 1'b0;

        test_idle_after_reset();
        test_reverse_keys();
        test_equal_runs();
        test_sparse();
        test_random_burst();

        $display("value errors: %0d, other failures: %0d", value_errors, fail_count);
        if (value_errors == 0 && fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/sort_reduce_top.sv
`timescale 1ns/1ps
`default_nettype none

module sort_reduce_top (
    input  logic                                clk,
    input  logic                                rst,
    input  sort_pkg::lane_vec_t                 batch_in,
    output sort_pkg::lane_item_t                result,
    output logic [sort_pkg::lane_idx_width-1:0] result_lane
);

    import sort_pkg::*;

    lane_vec_t             sorted;
    lane_vec_t             reduced;
    lane_item_t            fifo_head [lane_count];
    logic [lane_count-1:0] fifo_empty;
    logic [lane_count-1:0] fifo_pop;

    bitonic_sorter sorter_i (
        .clk      (clk),
        .rst      (rst),
        .batch_in (batch_in),
        .sorted   (sorted)
    );

    run_min_scan scan_i (
        .clk     (clk),
        .rst     (rst),
        .sorted  (sorted),
        .reduced (reduced)
    );

    // lane valid bit doubles as the write strobe
    for (genvar i = 0; i < lane_count; i++) begin : g_fifo
        lane_fifo fifo_i (
            .clk     (clk),
            .rst     (rst),
            .wr_item (reduced[i]),
            .pop     (fifo_pop[i]),
            .head    (fifo_head[i]),
            .empty   (fifo_empty[i])
        );
    end

    round_robin_drain drain_i (
        .clk         (clk),
        .rst         (rst),
        .heads       (fifo_head),
        .empty       (fifo_empty),
        .pop         (fifo_pop),
        .result      (result),
        .result_lane (result_lane)
    );

endmodule

`default_nettype wire

// File: hdl/round_robin_drain.sv
`timescale 1ns/1ps
`default_nettype none

module round_robin_drain (
    input  logic                                   clk,
    input  logic                                   rst,
    input  sort_pkg::lane_item_t                   heads [sort_pkg::lane_count],
    input  logic [sort_pkg::lane_count-1:0]        empty,
    output logic [sort_pkg::lane_count-1:0]        pop,
    output sort_pkg::lane_item_t                   result,
    output logic [sort_pkg::lane_idx_width-1:0]    result_lane
);

    import sort_pkg::*;

    logic [lane_idx_width-1:0] select;

    // one-hot pop, only when the selected lane has something
    always_comb begin
        pop = '0;
        pop[select] = !empty[select];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            select <= '0;
            result <= '0;
            result_lane <= '0;
        end else begin
            // wraps 7 -> 0 on its own
            select <= select + 1'b1;
            result.valid <= !empty[select];
            result.key <= heads[select].key;
            result.data <= heads[select].data;
            result_lane <= select;
        end
    end

endmodule

`default_nettype wire

// File: hdl/lane_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module lane_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  sort_pkg::lane_item_t wr_item,
    input  logic                 pop,
    output sort_pkg::lane_item_t head,
    output logic                 empty
);

    import sort_pkg::*;

    lane_item_t mem [fifo_depth];

    logic [fifo_ptr_width-1:0] rd_ptr;
    logic [fifo_ptr_width-1:0] wr_ptr;
    logic [fifo_ptr_width:0]   count;
    logic                      full;
    logic                      do_write;
    logic                      do_read;

    assign empty = count == '0;
    assign full = count == (fifo_ptr_width + 1)'(fifo_depth);
    assign do_write = wr_item.valid && !full;
    assign do_read = pop && !empty;

    // fall-through head
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_item;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/run_min_scan.sv
`timescale 1ns/1ps
`default_nettype none

module run_min_scan (
    input  logic                clk,
    input  logic                rst,
    input  sort_pkg::lane_vec_t sorted,
    output sort_pkg::lane_vec_t reduced
);

    import sort_pkg::*;

    // pull the lower data in when it belongs to the same run
    function automatic lane_item_t take_run_min(lane_item_t self, lane_item_t lower);
        lane_item_t res;
        res = self;
        if (self.valid && lower.valid && self.key == lower.key && lower.data < self.data) begin
            res.data = lower.data;
        end
        return res;
    endfunction

    for (genvar l = 0; l < lane_idx_width; l++) begin : g_level
        localparam int span = 1 << l;
        lane_vec_t d;
        lane_vec_t q;

        if (l == 0) begin : g_src
            assign d = sorted;
        end else begin : g_src
            assign d = g_level[l - 1].q;
        end

        // upper half of each block looks at the last lane of the lower half
        always_ff @(posedge clk) begin
            if (rst) begin
                q <= '0;
            end else begin
                for (int i = 0; i < lane_count; i++) begin
                    if ((i % (2 * span)) >= span) begin
                        q[i] <= take_run_min(d[i], d[i - (i % (2 * span)) + span - 1]);
                    end else begin
                        q[i] <= d[i];
                    end
                end
            end
        end
    end

    assign reduced = g_level[lane_idx_width - 1].q;

endmodule

`default_nettype wire

// File: hdl/bitonic_sorter.sv
`timescale 1ns/1ps
`default_nettype none

module bitonic_sorter (
    input  logic                clk,
    input  logic                rst,
    input  sort_pkg::lane_vec_t batch_in,
    output sort_pkg::lane_vec_t sorted
);

    import sort_pkg::*;

    localparam int stage_count = lane_idx_width * (lane_idx_width + 1) / 2;

    lane_vec_t level [stage_count + 1];

    assign level[0] = batch_in;

    // phase p sorts blocks of 2**p, the last phase is the ascending merge
    for (genvar p = 1; p <= lane_idx_width; p++) begin : g_phase
        for (genvar q = p; q >= 1; q--) begin : g_step
            localparam int idx = p * (p - 1) / 2 + (p - q);

            sort_stage #(
                .step (1 << (q - 1)),
                .run  (1 << p)
            ) stage_i (
                .clk       (clk),
                .rst       (rst),
                .stage_in  (level[idx]),
                .stage_out (level[idx + 1])
            );
        end
    end

    assign sorted = level[stage_count];

endmodule

`default_nettype wire

// File: hdl/sort_stage.sv
`timescale 1ns/1ps
`default_nettype none

module sort_stage #(
    parameter int step = 1,
    parameter int run = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  sort_pkg::lane_vec_t stage_in,
    output sort_pkg::lane_vec_t stage_out
);

    import sort_pkg::*;

    lane_item_t swapped [lane_count];

    // one compare-exchange per pair, lane i against lane i + step
    for (genvar i = 0; i < lane_count; i++) begin : g_lane
        if ((i % (2 * step)) < step) begin : g_pair
            localparam bit descend = ((i / run) % 2) == 1;
            logic keep;

            // descending blocks want the upper item first
            assign keep = descend ? item_before(stage_in[i + step], stage_in[i])
                                  : item_before(stage_in[i], stage_in[i + step]);
            assign swapped[i] = keep ? stage_in[i] : stage_in[i + step];
            assign swapped[i + step] = keep ? stage_in[i + step] : stage_in[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_out <= '0;
        end else begin
            for (int i = 0; i < lane_count; i++) begin
                stage_out[i] <= swapped[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/sort_pkg.sv
`default_nettype none

package sort_pkg;

    localparam int lane_count = 8;
    localparam int lane_idx_width = 3;
    localparam int key_width = 16;
    localparam int data_width = 32;
    localparam int fifo_depth = 16;
    localparam int fifo_ptr_width = 4;

    typedef struct packed {
        logic                  valid;
        logic [key_width-1:0]  key;
        logic [data_width-1:0] data;
    } lane_item_t;

    // lane 0 is the least significant element
    typedef lane_item_t [lane_count-1:0] lane_vec_t;

    // invalid items rank below every valid item
    function automatic logic item_before(lane_item_t a, lane_item_t b);
        if (!a.valid) begin
            return 1'b1;
        end
        return b.valid && (a.key <= b.key);
    endfunction

endpackage

`default_nettype wire
